/* rtl/serpc_config.svh */
`ifndef SERPC_CONFIG_SVH
`define SERPC_CONFIG_SVH

// first fetch address after reset
`define SERPC_RESET_PC 32'd8

`endif

/* rtl/serpc_pkg.sv */
package serpc_pkg;

   typedef enum logic [2:0] {
      OP_SEQ    = 3'd0,
      OP_JAL    = 3'd1,
      OP_JALR   = 3'd2,
      OP_BRANCH = 3'd3,
      OP_AUIPC  = 3'd4,
      OP_LUI    = 3'd5,
      OP_TRAP   = 3'd6
   } pc_op_e;

   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,
      ST_RUN   = 2'd1,
      ST_FETCH = 2'd2
   } seq_state_e;

endpackage

/* rtl/ser_ctrl_if.sv */
`timescale 1ns/1ps

interface ser_ctrl_if;

   // bit position
   logic       pc_en;
   logic [4:2] cnt;
   logic [2:1] cnt_r;
   logic       cnt_done;

   // decoded operation
   logic       jump;
   logic       jal_or_jalr;
   logic       utype;
   logic       pc_rel;
   logic       trap;

   // serial operands, lsb first
   logic       imm_bit;
   logic       buf_bit;
   logic       csr_pc_bit;

   // back from pc control
   logic       rd_bit;
   logic       bad_pc;
   logic       ibus_cyc;

   modport seq (
      output pc_en, cnt, cnt_r, cnt_done,
      output jump, jal_or_jalr, utype, pc_rel, trap,
      output imm_bit, buf_bit, csr_pc_bit,
      input  rd_bit, bad_pc, ibus_cyc
   );

   modport ctrl (
      input  pc_en, cnt, cnt_r, cnt_done,
      input  jump, jal_or_jalr, utype, pc_rel, trap,
      input  imm_bit, buf_bit, csr_pc_bit,
      output rd_bit, bad_pc, ibus_cyc
   );

endinterface

/* rtl/ser_add.sv */
`timescale 1ns/1ps

module ser_add (
   input  logic clk,
   input  logic i_rst,
   input  logic i_a,
   input  logic i_b,
   input  logic i_clr,
   output logic o_q
);

   logic carry_q;

   assign o_q = i_a ^ i_b ^ carry_q;

   // carry into the next bit position
   always_ff @(posedge clk) begin
      if (i_rst || i_clr) begin
         carry_q <= 1'b0;
      end else begin
         carry_q <= (i_a & i_b) | (carry_q & (i_a ^ i_b));
      end
   end

endmodule

/* rtl/pc_shift_reg.sv */
`timescale 1ns/1ps

module pc_shift_reg #(
   parameter logic [31:0] RESET_VAL = 32'd0
) (
   input  logic        clk,
   input  logic        i_rst,
   input  logic        i_en,
   input  logic        i_d,
   output logic        o_q,
   output logic [30:0] o_par
);

   logic [31:0] data_q;

   assign o_q   = data_q[0];
   assign o_par = data_q[31:1];

   // new bits enter at the top, old lsb leaves at the bottom
   always_ff @(posedge clk) begin
      if (i_rst) begin
         data_q <= RESET_VAL;
      end else if (i_en) begin
         data_q <= {i_d, data_q[31:1]};
      end
   end

endmodule

/* rtl/serial_pc_ctrl.sv */
`timescale 1ns/1ps

module serial_pc_ctrl #(
   parameter logic [31:0] RESET_PC = 32'd8
) (
   input  logic        clk,
   input  logic        i_rst,
   ser_ctrl_if.ctrl    bus,
   input  logic        i_ibus_ack,
   output logic [31:0] o_ibus_adr
);

   logic        en_pc_q;
   logic        pc;
   logic [30:0] pc_par;
   logic        plus_4;
   logic        pc_plus_4;
   logic        offset_a;
   logic        offset_b;
   logic        upper_imm;
   logic        pc_plus_offset;
   logic        target;
   logic        new_pc;

   // single one at bit 2
   assign plus_4 = bus.cnt_r[2] & (bus.cnt == 3'd0);

   ser_add ser_add_pc_plus_4 (
      .clk   (clk),
      .i_rst (i_rst),
      .i_a   (pc),
      .i_b   (plus_4),
      .i_clr (bus.cnt_done),
      .o_q   (pc_plus_4)
   );

   // upper immediate keeps bits 31:12
   assign upper_imm = bus.imm_bit & (bus.cnt[4] | (bus.cnt[3:2] == 2'b11));
   assign offset_a  = bus.pc_rel & pc;
   assign offset_b  = bus.utype ? upper_imm : bus.buf_bit;

   ser_add ser_add_pc_plus_offset (
      .clk   (clk),
      .i_rst (i_rst),
      .i_a   (offset_a),
      .i_b   (offset_b),
      .i_clr (~bus.pc_en),
      .o_q   (pc_plus_offset)
   );

   // flag is still low on bit 0, so targets and trap vectors come out even
   assign target = pc_plus_offset & en_pc_q;

   assign new_pc = bus.trap ? (bus.csr_pc_bit & en_pc_q) :
                   bus.jump ? target : pc_plus_4;

   pc_shift_reg #(
      .RESET_VAL (RESET_PC)
   ) pc_reg (
      .clk   (clk),
      .i_rst (i_rst),
      .i_en  (bus.pc_en),
      .i_d   (new_pc),
      .o_q   (pc),
      .o_par (pc_par)
   );

   assign bus.rd_bit   = (bus.utype & target) | (bus.jal_or_jalr & pc_plus_4);
   assign bus.bad_pc   = target;
   assign bus.ibus_cyc = en_pc_q & ~bus.pc_en;
   assign o_ibus_adr   = {pc_par, pc};

   // set while bits flow, cleared once the fetch is taken
   always_ff @(posedge clk) begin
      if (i_rst) begin
         en_pc_q <= 1'b1;
      end else if (bus.pc_en) begin
         en_pc_q <= 1'b1;
      end else if (bus.ibus_cyc && i_ibus_ack) begin
         en_pc_q <= 1'b0;
      end
   end

endmodule

/* rtl/op_sequencer.sv */
`timescale 1ns/1ps

module op_sequencer (
   input  logic              clk,
   input  logic              i_rst,
   input  logic              i_start,
   input  serpc_pkg::pc_op_e i_op,
   input  logic [31:0]       i_imm,
   input  logic [31:0]       i_rs1,
   input  logic [31:0]       i_trap_pc,
   ser_ctrl_if.seq           bus,
   output logic              o_busy,
   output logic              o_done,
   output logic              o_misaligned,
   output logic [31:0]       o_rd_data
);

   serpc_pkg::seq_state_e state;
   serpc_pkg::pc_op_e     op_q;
   logic [4:0]            cnt_q;
   logic [31:0]           imm_q;
   logic [31:0]           buf_q;
   logic [31:0]           trap_q;
   logic [31:0]           rd_q;
   logic                  mis_q;
   logic                  start;

   // reset fetch also counts as busy
   assign o_busy = (state != serpc_pkg::ST_IDLE) | bus.ibus_cyc;
   assign start  = i_start & ~o_busy;

   assign bus.pc_en    = (state == serpc_pkg::ST_RUN);
   assign bus.cnt      = cnt_q[4:2];
   assign bus.cnt_r[1] = (cnt_q[1:0] == 2'd1);
   assign bus.cnt_r[2] = (cnt_q[1:0] == 2'd2);
   assign bus.cnt_done = bus.pc_en & (cnt_q == 5'd31);

   assign bus.jump        = (op_q == serpc_pkg::OP_JAL) |
                            (op_q == serpc_pkg::OP_JALR) |
                            (op_q == serpc_pkg::OP_BRANCH);
   assign bus.jal_or_jalr = (op_q == serpc_pkg::OP_JAL) |
                            (op_q == serpc_pkg::OP_JALR);
   assign bus.utype       = (op_q == serpc_pkg::OP_AUIPC) |
                            (op_q == serpc_pkg::OP_LUI);
   assign bus.pc_rel      = (op_q == serpc_pkg::OP_JAL) |
                            (op_q == serpc_pkg::OP_BRANCH) |
                            (op_q == serpc_pkg::OP_AUIPC);
   assign bus.trap        = (op_q == serpc_pkg::OP_TRAP);

   assign bus.imm_bit    = imm_q[0];
   assign bus.buf_bit    = buf_q[0];
   assign bus.csr_pc_bit = trap_q[0];

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state        <= serpc_pkg::ST_IDLE;
         op_q         <= serpc_pkg::OP_SEQ;
         cnt_q        <= 5'd0;
         o_done       <= 1'b0;
         o_misaligned <= 1'b0;
         o_rd_data    <= 32'd0;
      end else begin
         o_done <= 1'b0;
         case (state)
            serpc_pkg::ST_IDLE: begin
               if (start) begin
                  state <= serpc_pkg::ST_RUN;
                  op_q  <= i_op;
               end
            end
            serpc_pkg::ST_RUN: begin
               // wraps back to 0 after bit 31
               cnt_q <= cnt_q + 5'd1;
               if (bus.cnt_done) begin
                  state <= serpc_pkg::ST_FETCH;
               end
            end
            serpc_pkg::ST_FETCH: begin
               if (!bus.ibus_cyc) begin
                  state        <= serpc_pkg::ST_IDLE;
                  o_done       <= 1'b1;
                  o_rd_data    <= rd_q;
                  o_misaligned <= mis_q;
               end
            end
            default: begin
               state <= serpc_pkg::ST_IDLE;
            end
         endcase
      end
   end

   // operand serializers and result collection
   always_ff @(posedge clk) begin
      if (start) begin
         imm_q  <= i_imm;
         buf_q  <= (i_op == serpc_pkg::OP_JALR) ? i_rs1 : i_imm;
         trap_q <= i_trap_pc;
      end else if (bus.pc_en) begin
         imm_q  <= {1'b0, imm_q[31:1]};
         buf_q  <= {1'b0, buf_q[31:1]};
         trap_q <= {1'b0, trap_q[31:1]};
         rd_q   <= {bus.rd_bit, rd_q[31:1]};
      end
      // target bit 1
      if (bus.pc_en && (bus.cnt == 3'd0) && bus.cnt_r[1]) begin
         mis_q <= bus.jump & bus.bad_pc;
      end
   end

endmodule

/* rtl/serial_pc_top.sv */
`timescale 1ns/1ps
`include "serpc_config.svh"

module serial_pc_top (
   input  logic              clk,
   input  logic              i_rst,
   input  logic              i_start,
   input  serpc_pkg::pc_op_e i_op,
   input  logic [31:0]       i_imm,
   input  logic [31:0]       i_rs1,
   input  logic [31:0]       i_trap_pc,
   input  logic              i_ibus_ack,
   output logic              o_busy,
   output logic              o_done,
   output logic [31:0]       o_rd_data,
   output logic              o_misaligned,
   output logic [31:0]       o_ibus_adr,
   output logic              o_ibus_cyc
);

   ser_ctrl_if ctrl_bus ();

   op_sequencer sequencer (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_start      (i_start),
      .i_op         (i_op),
      .i_imm        (i_imm),
      .i_rs1        (i_rs1),
      .i_trap_pc    (i_trap_pc),
      .bus          (ctrl_bus.seq),
      .o_busy       (o_busy),
      .o_done       (o_done),
      .o_misaligned (o_misaligned),
      .o_rd_data    (o_rd_data)
   );

   serial_pc_ctrl #(
      .RESET_PC (`SERPC_RESET_PC)
   ) pc_ctrl (
      .clk        (clk),
      .i_rst      (i_rst),
      .bus        (ctrl_bus.ctrl),
      .i_ibus_ack (i_ibus_ack),
      .o_ibus_adr (o_ibus_adr)
   );

   assign o_ibus_cyc = ctrl_bus.ibus_cyc;

endmodule

/* bench/serial_pc_properties.sv */
`timescale 1ns/1ps

module serial_pc_properties (
   input logic                  clk,
   input logic                  i_rst,
   input logic                  i_start,
   input logic                  o_busy,
   input logic                  o_done,
   input serpc_pkg::seq_state_e state,
   input logic [4:0]            cnt_q,
   input logic                  pc_en,
   input logic                  cnt_done,
   input logic                  ibus_cyc
);

   // run phase starts at bit 0 and steps one bit per cycle up to cnt_done
   a_run_first: assert property (@(posedge clk) disable iff (i_rst)
      $rose(pc_en) |-> cnt_q == 5'd0) else $error("pc_en rose off bit 0");
   a_run_step: assert property (@(posedge clk) disable iff (i_rst)
      pc_en && !cnt_done |=> pc_en && (cnt_q == $past(cnt_q) + 5'd1))
      else $error("pc_en dropped early or count skipped");
   a_run_end: assert property (@(posedge clk) disable iff (i_rst)
      cnt_done |=> !pc_en) else $error("pc_en ran past bit 31");

   // done only in the cycle after the fetch request falls
   a_done_after_fetch: assert property (@(posedge clk) disable iff (i_rst)
      o_done |-> !$past(ibus_cyc) && $past(ibus_cyc, 2))
      else $error("o_done without a finished fetch");

   a_busy_start: assert property (@(posedge clk) disable iff (i_rst)
      i_start && o_busy |=> !$rose(pc_en)) else $error("start taken while busy");

   // last bit comes 31 cycles into the run
   a_cnt_done: assert property (@(posedge clk) disable iff (i_rst)
      cnt_done |-> $past(pc_en, 31) && !$past(pc_en, 32))
      else $error("cnt_done off last bit");
   a_cnt_done_fetch: assert property (@(posedge clk) disable iff (i_rst)
      cnt_done |=> state == serpc_pkg::ST_FETCH && ibus_cyc)
      else $error("no fetch request after the last bit");

endmodule

bind op_sequencer serial_pc_properties props (
   .clk      (clk),
   .i_rst    (i_rst),
   .i_start  (i_start),
   .o_busy   (o_busy),
   .o_done   (o_done),
   .state    (state),
   .cnt_q    (cnt_q),
   .pc_en    (bus.pc_en),
   .cnt_done (bus.cnt_done),
   .ibus_cyc (bus.ibus_cyc)
);

/* bench/serial_pc_tb.sv */
`timescale 1ns/1ps
`include "serpc_config.svh"

module serial_pc_tb;

   localparam int N_OPS        = 200;
   localparam int RESET_CYCLES = 8;
   // start, 32 bits, fetch, up to 4 ack wait cycles, ack and done
   localparam int MAX_CYCLES   = 2 * (N_OPS * (33 + 4 + 3) + RESET_CYCLES);

   logic              clk;
   logic              i_rst;
   logic              i_start;
   serpc_pkg::pc_op_e i_op;
   logic [31:0]       i_imm;
   logic [31:0]       i_rs1;
   logic [31:0]       i_trap_pc;
   logic              i_ibus_ack;
   logic              o_busy;
   logic              o_done;
   logic [31:0]       o_rd_data;
   logic              o_misaligned;
   logic [31:0]       o_ibus_adr;
   logic              o_ibus_cyc;

   int                cycles = 0;
   int                checks = 0;
   int                errors = 0;
   logic [31:0]       pc_model;
   logic [31:0]       rd_model;
   logic              mis_model;

   serial_pc_top i_serial_pc_top (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_start      (i_start),
      .i_op         (i_op),
      .i_imm        (i_imm),
      .i_rs1        (i_rs1),
      .i_trap_pc    (i_trap_pc),
      .i_ibus_ack   (i_ibus_ack),
      .o_busy       (o_busy),
      .o_done       (o_done),
      .o_rd_data    (o_rd_data),
      .o_misaligned (o_misaligned),
      .o_ibus_adr   (o_ibus_adr),
      .o_ibus_cyc   (o_ibus_cyc)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("sim failed");
         $finish;
      end
   end

   task automatic check_word(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("MISMATCH t=%0t %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("MISMATCH t=%0t %s expected %b got %b", $time, name, exp, act);
      end
   endtask

   task automatic check_op(input string name, input serpc_pkg::pc_op_e exp,
                           input serpc_pkg::pc_op_e act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("MISMATCH t=%0t %s expected %s got %s", $time, name, exp.name(),
                  act.name());
      end
   endtask

   // called at a falling edge with the request up; holds it for delay cycles
   task automatic ack_fetch(input logic [31:0] adr, input int delay);
      int i;
      for (i = 0; i <= delay; i++) begin
         if (i > 0) begin
            @(negedge clk);
         end
         check_flag("o_ibus_cyc", 1'b1, o_ibus_cyc);
         check_word("o_ibus_adr", adr, o_ibus_adr);
      end
      @(posedge clk);
      #2 i_ibus_ack = 1'b1;
      @(posedge clk);
      #2 i_ibus_ack = 1'b0;
      @(negedge clk);
      check_flag("o_ibus_cyc", 1'b0, o_ibus_cyc);
   endtask

   task automatic run_op(input int n);
      serpc_pkg::pc_op_e op;
      logic [31:0]       imm;
      logic [31:0]       rs1;
      logic [31:0]       tvec;
      logic [31:0]       upper;
      logic [31:0]       target;
      logic [31:0]       next_pc;
      logic [31:0]       exp_rd;
      logic              exp_mis;
      int                delay;
      int                wait_cycles;
      int                err0;
      bit                poke;
      op    = serpc_pkg::pc_op_e'(3'($urandom_range(6)));
      imm   = $urandom;
      rs1   = $urandom;
      tvec  = $urandom;
      delay = $urandom_range(4);
      poke  = ($urandom_range(3) == 0);
      err0  = errors;

      // reference model, jump and trap targets lose bit 0
      upper   = imm & 32'hffff_f000;
      target  = ((op == serpc_pkg::OP_JALR) ? rs1 : pc_model + imm) & ~32'h1;
      next_pc = pc_model + 32'd4;
      exp_rd  = 32'd0;
      exp_mis = 1'b0;
      case (op)
         serpc_pkg::OP_JAL, serpc_pkg::OP_JALR: begin
            next_pc = target;
            exp_rd  = pc_model + 32'd4;
            exp_mis = target[1];
         end
         serpc_pkg::OP_BRANCH: begin
            next_pc = target;
            exp_mis = target[1];
         end
         serpc_pkg::OP_AUIPC: exp_rd = pc_model + upper;
         serpc_pkg::OP_LUI: exp_rd = upper;
         serpc_pkg::OP_TRAP: next_pc = tvec & ~32'h1;
         default: ;
      endcase

      @(posedge clk);
      #2;
      i_start   = 1'b1;
      i_op      = op;
      i_imm     = imm;
      i_rs1     = rs1;
      i_trap_pc = tvec;
      @(posedge clk);
      #2 i_start = 1'b0;

      wait_cycles = 0;
      do begin
         @(negedge clk);
         wait_cycles++;
         if (wait_cycles == 1) begin
            check_flag("o_done", 1'b0, o_done);
         end
         if (!o_ibus_cyc) begin
            check_flag("o_busy", 1'b1, o_busy);
         end
         // stray start with fresh operands in the middle of the run
         if (poke && (wait_cycles == 10 || wait_cycles == 11)) begin
            @(posedge clk);
            #2;
            i_start = (wait_cycles == 10);
            i_op    = serpc_pkg::pc_op_e'(3'($urandom_range(6)));
            i_imm   = $urandom;
            i_rs1   = $urandom;
         end
      end while (!o_ibus_cyc && wait_cycles < 40);

      check_word("cycles to o_ibus_cyc", 32'd33, 32'(wait_cycles));
      check_op("op_q", op, i_serial_pc_top.sequencer.op_q);
      check_word("o_rd_data", rd_model, o_rd_data);
      check_flag("o_misaligned", mis_model, o_misaligned);
      ack_fetch(next_pc, delay);
      check_flag("o_done", 1'b0, o_done);
      @(negedge clk);
      check_flag("o_done", 1'b1, o_done);
      check_flag("o_busy", 1'b0, o_busy);
      check_word("o_rd_data", exp_rd, o_rd_data);
      check_flag("o_misaligned", exp_mis, o_misaligned);

      pc_model  = next_pc;
      rd_model  = exp_rd;
      mis_model = exp_mis;
      $display("op %0d %s imm %h rs1 %h -> pc %h rd %h %s", n, op.name(), imm, rs1,
               next_pc, exp_rd, (errors == err0) ? "ok" : "FAIL");
   endtask

   initial begin
      int n;
      void'($urandom(32'hd7a431e3));
      i_rst      = 1'b1;
      i_start    = 1'b0;
      i_op       = serpc_pkg::OP_SEQ;
      i_imm      = 32'd0;
      i_rs1      = 32'd0;
      i_trap_pc  = 32'd0;
      i_ibus_ack = 1'b0;
      pc_model   = `SERPC_RESET_PC;
      rd_model   = 32'd0;
      mis_model  = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #2 i_rst = 1'b0;

      @(negedge clk);
      check_flag("o_busy", 1'b1, o_busy);
      check_flag("o_done", 1'b0, o_done);
      check_word("o_rd_data", 32'd0, o_rd_data);
      check_flag("o_misaligned", 1'b0, o_misaligned);
      // start during the reset fetch goes nowhere
      @(posedge clk);
      #2;
      i_start = 1'b1;
      i_op    = serpc_pkg::OP_JAL;
      @(posedge clk);
      #2 i_start = 1'b0;
      @(negedge clk);
      check_flag("o_busy", 1'b1, o_busy);
      ack_fetch(`SERPC_RESET_PC, $urandom_range(4));
      check_flag("o_busy", 1'b0, o_busy);
      check_flag("o_done", 1'b0, o_done);
      @(negedge clk);
      check_flag("o_busy", 1'b0, o_busy);
      $display("reset fetch at %h %s", pc_model, (errors == 0) ? "ok" : "FAIL");

      for (n = 0; n < N_OPS; n++) begin
         run_op(n);
      end

      $display("ops %0d checks %0d errors %0d", N_OPS, checks, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

/* sources.f */
+incdir+rtl
rtl/serpc_pkg.sv
rtl/ser_ctrl_if.sv
rtl/ser_add.sv
rtl/pc_shift_reg.sv
rtl/serial_pc_ctrl.sv
rtl/op_sequencer.sv
rtl/serial_pc_top.sv
bench/serial_pc_properties.sv
bench/serial_pc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sources.f --top-module serial_pc_tb \
   -o serial_pc_sim &&
   ./obj_dir/serial_pc_sim | tee sim.log
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
